//--- rtl/core_params.svh
// statistics core parameters
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// number of event counters in the bank.
`define STAT_COUNT 8

// bits needed to address one counter.
`define STAT_INDEX_W 3

// counter width, kept a whole number of bytes.
`define STAT_COUNT_W 32

// width of a single event increment.
`define STAT_INC_W 16

// byte answered by the ident command.
`define CORE_IDENT 8'h5a

`endif

//--- rtl/host_pkg.sv
// host protocol types
`default_nettype none

package host_pkg;

    // command opcodes as sent in the first host byte.
    typedef enum logic [7:0] {
        OP_IDENT      = 8'h00,
        OP_READ       = 8'h01,
        OP_READ_CLEAR = 8'h02
    } opcode_e;

    // status byte that leads every response.
    typedef enum logic [7:0] {
        ST_OK        = 8'h00,
        ST_BAD_OP    = 8'h01,
        ST_BAD_INDEX = 8'h02
    } status_e;

    typedef enum logic [2:0] {
        RX_OP,
        RX_INDEX,
        RX_OFFER,
        RX_WAIT_ACK,
        RX_WAIT_DROP
    } rx_state_e;

    typedef enum logic [1:0] {
        PROC_IDLE,
        PROC_RAISE,
        PROC_WAIT_ACK,
        PROC_WAIT_DROP
    } proc_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_LOAD,
        TX_WAIT_ACK,
        TX_WAIT_DROP
    } tx_state_e;

endpackage

`default_nettype wire

//--- rtl/stat_pkg.sv
// statistics value types
`default_nettype none

`include "core_params.svh"

package stat_pkg;

    // one counter value.
    typedef logic [`STAT_COUNT_W-1:0] stat_count_t;

    // counter index as it travels on the host link.
    typedef logic [7:0] stat_index_t;

    // one event increment.
    typedef logic [`STAT_INC_W-1:0] stat_inc_t;

endpackage

`default_nettype wire

//--- rtl/cmd_rx.sv
// host command assembly
`timescale 1ns/1ns
`default_nettype none

module cmd_rx
    import host_pkg::*;
    import stat_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,

    // host byte link, four-phase.
    input  wire logic        in_req,
    input  wire logic [7:0]  in_data,
    output logic             in_ack,

    // command hand-off to the decoder.
    output logic             cmd_req,
    input  wire logic        cmd_ack,
    output opcode_e          cmd_op,
    output stat_index_t      cmd_index
);

rx_state_e state;
logic take_byte;

// a new byte is offered and not yet acknowledged.
assign take_byte = in_req && !in_ack;

always_ff @(posedge clk) begin
    if (reset) begin
        state   <= RX_OP;
        in_ack  <= 1'b0;
        cmd_req <= 1'b0;
    end else begin
        case (state)
            RX_OP, RX_INDEX: begin
                if (take_byte) begin
                    in_ack <= 1'b1;
                end else if (!in_req && in_ack) begin
                    // byte transfer done once req has dropped.
                    in_ack <= 1'b0;
                    state  <= (state == RX_OP) ? RX_INDEX : RX_OFFER;
                end
            end
            RX_OFFER: begin
                cmd_req <= 1'b1;
                state   <= RX_WAIT_ACK;
            end
            RX_WAIT_ACK: begin
                if (cmd_ack) begin
                    cmd_req <= 1'b0;
                    state   <= RX_WAIT_DROP;
                end
            end
            RX_WAIT_DROP: begin
                // no new bytes until the decoder has released its ack.
                if (!cmd_ack) begin
                    state <= RX_OP;
                end
            end
            default: state <= RX_OP;
        endcase
    end
end

// command bytes, held stable while cmd_req is up.
always_ff @(posedge clk) begin
    if (take_byte && state == RX_OP) begin
        cmd_op <= opcode_e'(in_data);
    end
    if (take_byte && state == RX_INDEX) begin
        cmd_index <= stat_index_t'(in_data);
    end
end

endmodule

`default_nettype wire

//--- rtl/cmd_proc.sv
// statistics command decoder
`timescale 1ns/1ns
`default_nettype none

`include "core_params.svh"

module cmd_proc
    import host_pkg::*;
    import stat_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     reset,

    // command hand-off from the assembler.
    input  wire logic                     cmd_req,
    output logic                          cmd_ack,
    input  wire opcode_e                  cmd_op,
    input  wire stat_index_t              cmd_index,

    // response hand-off to the serializer.
    output logic                          rsp_req,
    input  wire logic                     rsp_ack,
    output status_e                       rsp_status,
    output logic [2:0]                    rsp_len,
    output stat_count_t                   rsp_data,

    // counter bank access.
    output logic [`STAT_INDEX_W-1:0]      rd_index,
    input  wire stat_count_t              rd_data,
    output logic                          rd_clear
);

proc_state_e state;
logic        take;
status_e     status_d;
logic [2:0]  len_d;
stat_count_t data_d;
logic        clear_d;

assign take     = (state == PROC_IDLE) && cmd_req && !cmd_ack;
assign rd_index = cmd_index[`STAT_INDEX_W-1:0];

// clear lands on the same edge that samples rd_data, so no event is lost.
assign rd_clear = take && clear_d;

always_comb begin
    status_d = ST_OK;
    len_d    = 3'd0;
    data_d   = '0;
    clear_d  = 1'b0;
    case (cmd_op)
        OP_IDENT: begin
            len_d  = 3'd1;
            data_d = stat_count_t'(`CORE_IDENT);
        end
        OP_READ, OP_READ_CLEAR: begin
            if (cmd_index < 8'(`STAT_COUNT)) begin
                len_d   = 3'(`STAT_COUNT_W / 8);
                data_d  = rd_data;
                clear_d = (cmd_op == OP_READ_CLEAR);
            end else begin
                status_d = ST_BAD_INDEX;
            end
        end
        default: status_d = ST_BAD_OP;
    endcase
end

always_ff @(posedge clk) begin
    if (reset) begin
        state   <= PROC_IDLE;
        cmd_ack <= 1'b0;
        rsp_req <= 1'b0;
    end else begin
        // command ack runs its own four-phase cycle.
        if (take) begin
            cmd_ack <= 1'b1;
        end else if (cmd_ack && !cmd_req) begin
            cmd_ack <= 1'b0;
        end

        case (state)
            PROC_IDLE: begin
                if (take) begin
                    state <= PROC_RAISE;
                end
            end
            PROC_RAISE: begin
                rsp_req <= 1'b1;
                state   <= PROC_WAIT_ACK;
            end
            PROC_WAIT_ACK: begin
                if (rsp_ack) begin
                    rsp_req <= 1'b0;
                    state   <= PROC_WAIT_DROP;
                end
            end
            PROC_WAIT_DROP: begin
                if (!rsp_ack) begin
                    state <= PROC_IDLE;
                end
            end
            default: state <= PROC_IDLE;
        endcase
    end
end

// response payload.
always_ff @(posedge clk) begin
    if (take) begin
        rsp_status <= status_d;
        rsp_len    <= len_d;
        rsp_data   <= data_d;
    end
end

endmodule

`default_nettype wire

//--- rtl/stat_bank.sv
// event counter bank
`timescale 1ns/1ns
`default_nettype none

`include "core_params.svh"

module stat_bank
    import stat_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     reset,

    // event strobe, one increment per cycle.
    input  wire logic                     stat_valid,
    input  wire logic [`STAT_INDEX_W-1:0] stat_id,
    input  wire stat_inc_t                stat_inc,

    // read and clear port.
    input  wire logic [`STAT_INDEX_W-1:0] rd_index,
    output stat_count_t                   rd_data,
    input  wire logic                     rd_clear
);

stat_count_t cnt [`STAT_COUNT];
stat_count_t cnt_next [`STAT_COUNT];

assign rd_data = cnt[rd_index];

// clear first, then add, so a colliding increment survives the clear.
always_comb begin
    for (int i = 0; i < `STAT_COUNT; i++) begin
        cnt_next[i] = cnt[i];
        if (rd_clear && int'(rd_index) == i) begin
            cnt_next[i] = '0;
        end
        if (stat_valid && int'(stat_id) == i) begin
            // wraps naturally at the counter width.
            cnt_next[i] = cnt_next[i] + stat_count_t'(stat_inc);
        end
    end
end

always_ff @(posedge clk) begin
    for (int i = 0; i < `STAT_COUNT; i++) begin
        if (reset) begin
            cnt[i] <= '0;
        end else begin
            cnt[i] <= cnt_next[i];
        end
    end
end

endmodule

`default_nettype wire

//--- rtl/rsp_tx.sv
// host response serializer
`timescale 1ns/1ns
`default_nettype none

`include "core_params.svh"

module rsp_tx
    import host_pkg::*;
    import stat_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,

    // response hand-off from the decoder.
    input  wire logic        rsp_req,
    output logic             rsp_ack,
    input  wire status_e     rsp_status,
    input  wire logic [2:0]  rsp_len,
    input  wire stat_count_t rsp_data,

    // host byte link, four-phase.
    output logic             out_req,
    input  wire logic        out_ack,
    output logic [7:0]       out_data
);

tx_state_e   state;
logic        take;
status_e     status_q;
logic [2:0]  remain_q;
stat_count_t shift_q;

assign take = (state == TX_IDLE) && rsp_req && !rsp_ack;

always_ff @(posedge clk) begin
    if (reset) begin
        state   <= TX_IDLE;
        rsp_ack <= 1'b0;
        out_req <= 1'b0;
    end else begin
        // decoder is released as soon as the response is latched.
        if (take) begin
            rsp_ack <= 1'b1;
        end else if (rsp_ack && !rsp_req) begin
            rsp_ack <= 1'b0;
        end

        case (state)
            TX_IDLE: begin
                if (take) begin
                    state <= TX_LOAD;
                end
            end
            TX_LOAD: begin
                out_req <= 1'b1;
                state   <= TX_WAIT_ACK;
            end
            TX_WAIT_ACK: begin
                if (out_ack) begin
                    out_req <= 1'b0;
                    state   <= TX_WAIT_DROP;
                end
            end
            TX_WAIT_DROP: begin
                if (!out_ack) begin
                    if (remain_q != 3'd0) begin
                        out_req <= 1'b1;
                        state   <= TX_WAIT_ACK;
                    end else begin
                        state <= TX_IDLE;
                    end
                end
            end
            default: state <= TX_IDLE;
        endcase
    end
end

// byte datapath. payload is left aligned so the top byte always goes next.
always_ff @(posedge clk) begin
    if (take) begin
        status_q <= rsp_status;
        remain_q <= rsp_len;
        shift_q  <= rsp_data << (8 * (`STAT_COUNT_W / 8 - int'(rsp_len)));
    end else if (state == TX_LOAD) begin
        out_data <= status_q;
    end else if (state == TX_WAIT_DROP && !out_ack && remain_q != 3'd0) begin
        out_data <= shift_q[`STAT_COUNT_W-1 -: 8];
        shift_q  <= shift_q << 8;
        remain_q <= remain_q - 3'd1;
    end
end

endmodule

`default_nettype wire

//--- rtl/stats_core.sv
// statistics core top level
`timescale 1ns/1ns
`default_nettype none

`include "core_params.svh"

module stats_core
    import host_pkg::*;
    import stat_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     reset,

    // host command bytes in.
    input  wire logic                     in_req,
    input  wire logic [7:0]               in_data,
    output wire logic                     in_ack,

    // host response bytes out.
    output wire logic                     out_req,
    input  wire logic                     out_ack,
    output wire logic [7:0]               out_data,

    // event increment strobe.
    input  wire logic                     stat_valid,
    input  wire logic [`STAT_INDEX_W-1:0] stat_id,
    input  wire stat_inc_t                stat_inc
);

logic                     cmd_req;
logic                     cmd_ack;
opcode_e                  cmd_op;
stat_index_t              cmd_index;

logic                     rsp_req;
logic                     rsp_ack;
status_e                  rsp_status;
logic [2:0]               rsp_len;
stat_count_t              rsp_data;

logic [`STAT_INDEX_W-1:0] rd_index;
stat_count_t              rd_data;
logic                     rd_clear;

cmd_rx cmd_rx_inst (
    .clk(clk),
    .reset(reset),
    .in_req(in_req),
    .in_data(in_data),
    .in_ack(in_ack),
    .cmd_req(cmd_req),
    .cmd_ack(cmd_ack),
    .cmd_op(cmd_op),
    .cmd_index(cmd_index)
);

cmd_proc cmd_proc_inst (
    .clk(clk),
    .reset(reset),
    .cmd_req(cmd_req),
    .cmd_ack(cmd_ack),
    .cmd_op(cmd_op),
    .cmd_index(cmd_index),
    .rsp_req(rsp_req),
    .rsp_ack(rsp_ack),
    .rsp_status(rsp_status),
    .rsp_len(rsp_len),
    .rsp_data(rsp_data),
    .rd_index(rd_index),
    .rd_data(rd_data),
    .rd_clear(rd_clear)
);

stat_bank stat_bank_inst (
    .clk(clk),
    .reset(reset),
    .stat_valid(stat_valid),
    .stat_id(stat_id),
    .stat_inc(stat_inc),
    .rd_index(rd_index),
    .rd_data(rd_data),
    .rd_clear(rd_clear)
);

rsp_tx rsp_tx_inst (
    .clk(clk),
    .reset(reset),
    .rsp_req(rsp_req),
    .rsp_ack(rsp_ack),
    .rsp_status(rsp_status),
    .rsp_len(rsp_len),
    .rsp_data(rsp_data),
    .out_req(out_req),
    .out_ack(out_ack),
    .out_data(out_data)
);

endmodule

`default_nettype wire

//--- tb/tb_stats_core.sv
// statistics core testbench
`timescale 1ns/1ns
`default_nettype none

`include "core_params.svh"

module tb_stats_core
    import host_pkg::*;
    import stat_pkg::*;
();

// the wrap preload takes most of the run.
localparam int WRAP_STEPS     = 65537;
localparam int TIMEOUT_CYCLES = 4 * (WRAP_STEPS + 5000);

logic                     clk;
logic                     reset;
logic                     in_req;
logic [7:0]               in_data;
logic                     in_ack;
logic                     out_req;
logic                     out_ack;
logic [7:0]               out_data;
logic                     stat_valid;
logic [`STAT_INDEX_W-1:0] stat_id;
stat_inc_t                stat_inc;

// reference copy of the counter bank.
stat_count_t model [`STAT_COUNT];
logic [7:0]  expect_q [$];
integer      seed;
int          hold_extra;
int          cycle_count = 0;

logic        prev_in_req;
logic [7:0]  prev_in_data;
logic        prev_out_req;
logic [7:0]  prev_out_data;

stats_core dut (
    .clk(clk),
    .reset(reset),
    .in_req(in_req),
    .in_data(in_data),
    .in_ack(in_ack),
    .out_req(out_req),
    .out_ack(out_ack),
    .out_data(out_data),
    .stat_valid(stat_valid),
    .stat_id(stat_id),
    .stat_inc(stat_inc)
);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (actual == expected) else
        report_failure($sformatf("Fail %s expected 0x%0h actual 0x%0h",
                                 name, expected, actual));
endtask

// one four-phase byte transfer towards the core.
task automatic send_byte(input logic [7:0] value);
    while (in_ack) @(posedge clk);
    @(posedge clk);
    in_req  <= 1'b1;
    in_data <= value;
    do @(posedge clk); while (!in_ack);
    in_req <= 1'b0;
    do @(posedge clk); while (in_ack);
endtask

// host side of the response link, ack held off for a random while.
task automatic recv_byte(output logic [7:0] value);
    logic [31:0] rnd;
    int          hold;
    do @(posedge clk); while (!out_req);
    value = out_data;
    rnd   = $random(seed);
    hold  = hold_extra + int'(rnd % 32'd6);
    repeat (hold) @(posedge clk);
    out_ack <= 1'b1;
    do @(posedge clk); while (out_req);
    out_ack <= 1'b0;
endtask

// back to back increments of one counter, mirrored in the model.
task automatic apply_events(input logic [`STAT_INDEX_W-1:0] id, input stat_inc_t inc,
                            input int count);
    int k;
    for (k = 0; k < count; k++) begin
        @(posedge clk);
        stat_valid <= 1'b1;
        stat_id    <= id;
        stat_inc   <= inc;
        model[id] = model[id] + stat_count_t'(inc);
    end
    @(posedge clk);
    stat_valid <= 1'b0;
endtask

// expected response bytes for one command.
task automatic push_expected(input logic [7:0] op, input logic [7:0] idx);
    stat_count_t value;
    int          k;
    if (op == OP_IDENT) begin
        expect_q.push_back(8'h00);
        expect_q.push_back(`CORE_IDENT);
    end else if (op == OP_READ || op == OP_READ_CLEAR) begin
        if (int'(idx) >= `STAT_COUNT) begin
            expect_q.push_back(8'h02);
        end else begin
            value = model[idx[`STAT_INDEX_W-1:0]];
            expect_q.push_back(8'h00);
            // most significant byte first.
            for (k = `STAT_COUNT_W / 8 - 1; k >= 0; k--) begin
                expect_q.push_back(value[8*k +: 8]);
            end
            if (op == OP_READ_CLEAR) begin
                model[idx[`STAT_INDEX_W-1:0]] = '0;
            end
        end
    end else begin
        expect_q.push_back(8'h01);
    end
endtask

task automatic run_command(input logic [7:0] op, input logic [7:0] idx);
    logic [7:0] got;
    int         n;
    int         k;
    push_expected(op, idx);
    n = expect_q.size();
    send_byte(op);
    send_byte(idx);
    for (k = 0; k < n; k++) begin
        recv_byte(got);
        check_value("out_data", 32'(expect_q.pop_front()), 32'(got));
    end
endtask

// commands pile up in the core while the host is slow to take bytes.
task automatic run_batch();
    logic [7:0] cmd_bytes [$];
    logic [7:0] got;
    int         n;
    int         k;
    int         m;
    // opcode and index pairs, last two are a bad opcode and a bad index.
    cmd_bytes = '{8'h00, 8'h00, 8'h01, 8'h00, 8'h02, 8'h02, 8'h01, 8'h02,
                  8'h01, 8'h07, 8'h07, 8'h01, 8'h01, 8'h0c};
    for (k = 0; k < cmd_bytes.size(); k += 2) begin
        push_expected(cmd_bytes[k], cmd_bytes[k+1]);
    end
    n = expect_q.size();
    hold_extra = 20;
    fork
        begin
            for (k = 0; k < cmd_bytes.size(); k++) begin
                send_byte(cmd_bytes[k]);
            end
        end
        begin
            for (m = 0; m < n; m++) begin
                recv_byte(got);
                check_value("out_data", 32'(expect_q.pop_front()), 32'(got));
            end
        end
    join
    hold_extra = 0;
    // nothing extra may follow the last response.
    repeat (20) begin
        @(posedge clk);
        check_value("out_req", 32'h0, 32'(out_req));
    end
endtask

// four-phase rules on both host links.
always @(posedge clk) begin
    if (reset) begin
        prev_in_req   <= 1'b0;
        prev_in_data  <= 8'h00;
        prev_out_req  <= 1'b0;
        prev_out_data <= 8'h00;
    end else begin
        assert (!(in_req && !prev_in_req && in_ack)) else
            report_failure("in_req rose while in_ack was still high");
        assert (!(in_req && prev_in_req && in_data != prev_in_data)) else
            report_failure("in_data changed while in_req was high");
        assert (!(out_req && !prev_out_req && out_ack)) else
            report_failure("out_req rose while out_ack was still high");
        assert (!(out_req && prev_out_req && out_data != prev_out_data)) else
            report_failure("out_data changed while out_req was high");
        prev_in_req   <= in_req;
        prev_in_data  <= in_data;
        prev_out_req  <= out_req;
        prev_out_data <= out_data;
    end
end

always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
        report_failure("run did not finish within the cycle limit");
    end
end

initial begin
    int          i;
    int          j;
    logic [31:0] rnd;
    seed       = 32'h4c11e66f;
    hold_extra = 0;
    reset      = 1'b1;
    in_req     = 1'b0;
    in_data    = 8'h00;
    out_ack    = 1'b0;
    stat_valid = 1'b0;
    stat_id    = '0;
    stat_inc   = '0;
    for (i = 0; i < `STAT_COUNT; i++) begin
        model[i] = '0;
    end

    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    @(posedge clk);
    check_value("out_req", 32'h0, 32'(out_req));
    check_value("in_ack", 32'h0, 32'(in_ack));
    run_command(OP_IDENT, 8'h00);

    // random traffic over every counter, then two full read passes.
    for (i = 0; i < 200; i++) begin
        rnd = $random(seed);
        apply_events(rnd[2:0], rnd[31:16], 1 + int'(rnd[5:4]));
    end
    for (j = 0; j < 2; j++) begin
        for (i = 0; i < `STAT_COUNT; i++) begin
            run_command(OP_READ, 8'(i));
        end
    end

    run_command(OP_READ_CLEAR, 8'h03);
    apply_events(3'd3, 16'h0042, 3);
    apply_events(3'd4, 16'h1000, 2);
    run_command(OP_READ, 8'h03);

    // 65537 steps of 16'hffff land exactly on the all-ones value.
    run_command(OP_READ_CLEAR, 8'h05);
    apply_events(3'd5, 16'hffff, WRAP_STEPS);
    run_command(OP_READ, 8'h05);
    apply_events(3'd5, 16'h0123, 1);
    run_command(OP_READ, 8'h05);

    run_command(8'h07, 8'h00);
    run_command(OP_READ_CLEAR, 8'h09);
    run_command(OP_READ, 8'h01);

    run_batch();

    $display("Test passed");
    $finish;
end

endmodule

`default_nettype wire

//--- project.f
+incdir+rtl
rtl/host_pkg.sv
rtl/stat_pkg.sv
rtl/cmd_rx.sv
rtl/cmd_proc.sv
rtl/stat_bank.sv
rtl/rsp_tx.sv
rtl/stats_core.sv
tb/tb_stats_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build the statistics core testbench with Verilator and run it.
# The simulator exits non-zero when the testbench stops with $fatal.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ns \
    --top-module tb_stats_core \
    -Mdir obj_dir \
    -f project.f

./obj_dir/Vtb_stats_core
